/* hw/div_consts.svh */
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------
`define DIV_XLEN        64   // Register width
`define DIV_STEP_BITS   4    // Quotient bits retired per clock

// ----------------------------------------
// Iteration counts
// ----------------------------------------
`define DIV_STEPS_64    16   // 64 / 4
`define DIV_STEPS_32    8    // 32 / 4

// ----------------------------------------
// Bookkeeping widths
// ----------------------------------------
`define DIV_TAG_W       6
`define DIV_CNT_W       5    // Must hold DIV_STEPS_64

`endif

/* hw/div_isa_pkg.sv */
`include "div_consts.svh"

package div_isa_pkg;

    // One data word
    typedef logic [`DIV_XLEN-1:0] xlen_t;

    // Bit positions inside the operation code
    localparam int DIV_OP_UNS_BIT  = 0;   // Unsigned operands
    localparam int DIV_OP_REM_BIT  = 1;   // Remainder instead of quotient
    localparam int DIV_OP_WORD_BIT = 2;   // 32-bit W form

    // Encoding follows the three flag bits above
    typedef enum logic [2:0] {
        OP_DIV   = 3'b000,
        OP_DIVU  = 3'b001,
        OP_REM   = 3'b010,
        OP_REMU  = 3'b011,
        OP_DIVW  = 3'b100,
        OP_DIVUW = 3'b101,
        OP_REMW  = 3'b110,
        OP_REMUW = 3'b111
    } div_op_e;

endpackage

/* hw/div_pipe_pkg.sv */
`include "div_consts.svh"

package div_pipe_pkg;

    // Opaque pipeline tag, returned with the result
    typedef logic [`DIV_TAG_W-1:0] div_tag_t;

    // Remaining radix-16 steps in a lane
    typedef logic [`DIV_CNT_W-1:0] div_cnt_t;

endpackage

/* hw/div_lane_if.sv */
`timescale 1ns/1ps

interface div_lane_if
    import div_isa_pkg::*;
    import div_pipe_pkg::*;
();

    // ----------------------------------------
    // Issue side
    // ----------------------------------------
    logic     start;          // Single-cycle load pulse
    logic     is_rem;
    logic     is_word;
    logic     div_zero;
    logic     neg_quot;
    logic     neg_rem;
    xlen_t    dividend_mag;
    xlen_t    divisor_mag;
    div_tag_t tag;
    logic     grant;          // Result taken this cycle

    // ----------------------------------------
    // Lane side
    // ----------------------------------------
    logic     busy;
    logic     done;
    xlen_t    result;
    div_tag_t result_tag;

    modport issue (
        output start, is_rem, is_word, div_zero, neg_quot, neg_rem,
        output dividend_mag, divisor_mag, tag, grant,
        input  busy, done, result, result_tag
    );

    modport lane (
        input  start, is_rem, is_word, div_zero, neg_quot, neg_rem,
        input  dividend_mag, divisor_mag, tag, grant,
        output busy, done, result, result_tag
    );

endinterface

/* hw/div_operand_prep.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep
    import div_isa_pkg::*;
(
    input  div_op_e op_i,
    input  xlen_t   rs1_i,
    input  xlen_t   rs2_i,
    output logic    is_rem_o,
    output logic    is_word_o,
    output logic    div_zero_o,
    output logic    neg_quot_o,
    output logic    neg_rem_o,
    output xlen_t   dividend_mag_o,
    output xlen_t   divisor_mag_o
);

    localparam int HALF = `DIV_XLEN / 2;

    logic            signed_op;
    logic            sign_a;
    logic            sign_b;
    xlen_t           abs_a;
    xlen_t           abs_b;
    logic [HALF-1:0] abs_a_w;
    logic [HALF-1:0] abs_b_w;

    // Opcode decode
    assign signed_op = ~op_i[DIV_OP_UNS_BIT];
    assign is_rem_o  = op_i[DIV_OP_REM_BIT];
    assign is_word_o = op_i[DIV_OP_WORD_BIT];

    // Sign bit depends on operand width
    assign sign_a = signed_op & (is_word_o ? rs1_i[HALF-1] : rs1_i[`DIV_XLEN-1]);
    assign sign_b = signed_op & (is_word_o ? rs2_i[HALF-1] : rs2_i[`DIV_XLEN-1]);

    assign abs_a   = sign_a ? -rs1_i : rs1_i;
    assign abs_b   = sign_b ? -rs2_i : rs2_i;
    assign abs_a_w = sign_a ? -rs1_i[HALF-1:0] : rs1_i[HALF-1:0];
    assign abs_b_w = sign_b ? -rs2_i[HALF-1:0] : rs2_i[HALF-1:0];

    // W dividend sits in the upper half so 8 steps shift it all through
    assign dividend_mag_o = is_word_o ? {abs_a_w, {HALF{1'b0}}} : abs_a;
    assign divisor_mag_o  = is_word_o ? {{HALF{1'b0}}, abs_b_w} : abs_b;

    assign div_zero_o = is_word_o ? (rs2_i[HALF-1:0] == '0) : (rs2_i == '0);
    assign neg_quot_o = sign_a ^ sign_b;
    assign neg_rem_o  = sign_a;         // Remainder follows the dividend

endmodule

/* hw/div_radix16_step.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_radix16_step
    import div_isa_pkg::*;
(
    input  xlen_t rem_i,
    input  xlen_t quot_i,
    input  xlen_t divisor_i,
    output xlen_t rem_o,
    output xlen_t quot_o
);

    logic [`DIV_XLEN:0] rem_sh;     // One extra bit for the shifted-out carry
    logic [`DIV_XLEN:0] div_ext;
    xlen_t              rem_v;
    xlen_t              quot_v;

    assign div_ext = {1'b0, divisor_i};

    // Four restoring shift-subtract iterations
    always_comb begin
        rem_v  = rem_i;
        quot_v = quot_i;
        rem_sh = '0;
        for (int i = 0; i < `DIV_STEP_BITS; i++) begin
            rem_sh = {rem_v, quot_v[`DIV_XLEN-1]};
            quot_v = {quot_v[`DIV_XLEN-2:0], 1'b0};
            if (rem_sh >= div_ext) begin
                rem_sh    = rem_sh - div_ext;
                quot_v[0] = 1'b1;               // New quotient bit
            end
            rem_v = rem_sh[`DIV_XLEN-1:0];      // Always below divisor here
        end
    end

    assign rem_o  = rem_v;
    assign quot_o = quot_v;

endmodule

/* hw/div_lane.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_lane
    import div_isa_pkg::*;
    import div_pipe_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    div_lane_if.lane   lane
);

    localparam int HALF = `DIV_XLEN / 2;

    // Control state
    logic     busy_q;
    logic     done_q;
    div_cnt_t cnt_q;
    logic     running;
    logic     finish;

    // Operation payload
    xlen_t    rem_q;
    xlen_t    quot_q;
    xlen_t    divisor_q;
    logic     is_rem_q;
    logic     is_word_q;
    logic     div_zero_q;
    logic     neg_quot_q;
    logic     neg_rem_q;
    div_tag_t tag_q;
    xlen_t    result_q;

    xlen_t    step_rem;
    xlen_t    step_quot;
    xlen_t    quot_fix;
    xlen_t    rem_fix;
    xlen_t    res_raw;
    xlen_t    res_final;

    assign running = busy_q & ~done_q & (cnt_q != '0);
    assign finish  = busy_q & ~done_q & (cnt_q == '0);   // Last step already taken

    div_radix16_step u_step (
        .rem_i     (rem_q),
        .quot_i    (quot_q),
        .divisor_i (divisor_q),
        .rem_o     (step_rem),
        .quot_o    (step_quot)
    );

    // ----------------------------------------
    // Result fix-up
    // ----------------------------------------
    assign quot_fix = neg_quot_q ? -quot_q : quot_q;
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;   // Div by zero leaves the dividend here

    assign res_raw = is_rem_q   ? rem_fix :
                     div_zero_q ? '1 : quot_fix;

    assign res_final = is_word_q ? {{HALF{res_raw[HALF-1]}}, res_raw[HALF-1:0]} : res_raw;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (lane.start) begin
            busy_q <= 1'b1;
            cnt_q  <= lane.is_word ? div_cnt_t'(`DIV_STEPS_32) : div_cnt_t'(`DIV_STEPS_64);
        end else if (running) begin
            cnt_q <= cnt_q - div_cnt_t'(1);
        end else if (finish) begin
            done_q <= 1'b1;
        end else if (done_q && lane.grant) begin
            done_q <= 1'b0;             // Lane is free from the next cycle
            busy_q <= 1'b0;
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (lane.start) begin
            rem_q      <= '0;
            quot_q     <= lane.dividend_mag;
            divisor_q  <= lane.divisor_mag;
            is_rem_q   <= lane.is_rem;
            is_word_q  <= lane.is_word;
            div_zero_q <= lane.div_zero;
            neg_quot_q <= lane.neg_quot;
            neg_rem_q  <= lane.neg_rem;
            tag_q      <= lane.tag;
        end else if (running) begin
            rem_q  <= step_rem;
            quot_q <= step_quot;
        end else if (finish) begin
            result_q <= res_final;      // Held until granted
        end
    end

    assign lane.busy       = busy_q;
    assign lane.done       = done_q;
    assign lane.result     = result_q;
    assign lane.result_tag = tag_q;

endmodule

/* hw/div_unit.sv */
`timescale 1ns/1ps

module div_unit
    import div_isa_pkg::*;
    import div_pipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     flush_i,
    input  logic     in_valid_i,
    input  div_op_e  in_op_i,
    input  xlen_t    in_rs1_i,
    input  xlen_t    in_rs2_i,
    input  div_tag_t in_tag_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output xlen_t    out_result_o,
    output div_tag_t out_tag_o
);

    localparam int NUM_LANES = 2;

    logic                 is_rem;
    logic                 is_word;
    logic                 div_zero;
    logic                 neg_quot;
    logic                 neg_rem;
    xlen_t                dividend_mag;
    xlen_t                divisor_mag;
    logic                 take;
    logic [NUM_LANES-1:0] busy;
    logic [NUM_LANES-1:0] done;
    logic [NUM_LANES-1:0] sel;
    logic [NUM_LANES-1:0] grant;
    xlen_t                result [NUM_LANES];
    div_tag_t             result_tag [NUM_LANES];

    div_operand_prep u_prep (
        .op_i           (in_op_i),
        .rs1_i          (in_rs1_i),
        .rs2_i          (in_rs2_i),
        .is_rem_o       (is_rem),
        .is_word_o      (is_word),
        .div_zero_o     (div_zero),
        .neg_quot_o     (neg_quot),
        .neg_rem_o      (neg_rem),
        .dividend_mag_o (dividend_mag),
        .divisor_mag_o  (divisor_mag)
    );

    // ----------------------------------------
    // Lane allocation, lowest free lane first
    // ----------------------------------------
    assign in_ready_o = ~&busy;
    assign take       = in_valid_i & in_ready_o;
    assign sel[0]     = take & ~busy[0];
    assign sel[1]     = take & busy[0] & ~busy[1];

    // Lane 0 wins a same-cycle finish, lane 1 holds
    assign grant[0] = done[0];
    assign grant[1] = done[1] & ~done[0];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane_if lane_if ();

        assign lane_if.start        = sel[i];
        assign lane_if.is_rem       = is_rem;
        assign lane_if.is_word      = is_word;
        assign lane_if.div_zero     = div_zero;
        assign lane_if.neg_quot     = neg_quot;
        assign lane_if.neg_rem      = neg_rem;
        assign lane_if.dividend_mag = dividend_mag;
        assign lane_if.divisor_mag  = divisor_mag;
        assign lane_if.tag          = in_tag_i;
        assign lane_if.grant        = grant[i];

        assign busy[i]       = lane_if.busy;
        assign done[i]       = lane_if.done;
        assign result[i]     = lane_if.result;
        assign result_tag[i] = lane_if.result_tag;

        div_lane u_lane (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .flush_i (flush_i),
            .lane    (lane_if.lane)
        );
    end

    // Output mux, nothing shown while a flush kills the lanes
    assign out_valid_o  = (|done) & ~flush_i;
    assign out_result_o = grant[0] ? result[0] : result[1];
    assign out_tag_o    = grant[0] ? result_tag[0] : result_tag[1];

endmodule

/* tests/tb_div_unit.sv */
`timescale 1ns/1ps

module tb_div_unit
    import div_isa_pkg::*;
    import div_pipe_pkg::*;
();

    localparam int NUM_RAND   = 96;
    localparam int NUM_TAGS   = 64;
    localparam int MAX_CYCLES = (NUM_RAND + 24) * 32 + 160;   // About 120 ops at worst latency

    logic     clk;
    logic     rstn;
    logic     flush;
    logic     in_valid;
    div_op_e  in_op;
    xlen_t    in_rs1;
    xlen_t    in_rs2;
    div_tag_t in_tag;
    logic     in_ready;
    logic     out_valid;
    xlen_t    out_result;
    div_tag_t out_tag;

    // Model state per tag
    xlen_t    exp_result [NUM_TAGS];
    logic     word_op [NUM_TAGS];
    int       issue_cyc [NUM_TAGS];
    int       sent [NUM_TAGS];
    int       got [NUM_TAGS];
    int       killed [NUM_TAGS];
    int       issued = 0;
    int       received = 0;
    int       killed_total = 0;
    int       cyc = 0;
    logic     saw_full = 1'b0;
    div_tag_t next_tag = '0;
    integer   seed;

    div_unit u_div_unit (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .flush_i      (flush),
        .in_valid_i   (in_valid),
        .in_op_i      (in_op),
        .in_rs1_i     (in_rs1),
        .in_rs2_i     (in_rs2),
        .in_tag_i     (in_tag),
        .in_ready_o   (in_ready),
        .out_valid_o  (out_valid),
        .out_result_o (out_result),
        .out_tag_o    (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_with(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    // ----------------------------------------
    // RISC-V divide rules
    // ----------------------------------------
    function automatic xlen_t expected_result(input div_op_e op, input xlen_t a, input xlen_t b);
        logic        uns;
        logic        rem;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] r32;
        xlen_t       r;
        uns = op[DIV_OP_UNS_BIT];
        rem = op[DIV_OP_REM_BIT];
        a32 = a[31:0];
        b32 = b[31:0];
        if (op[DIV_OP_WORD_BIT]) begin
            if (b32 == '0)
                r32 = rem ? a32 : '1;
            else if (!uns && a32 == 32'h8000_0000 && b32 == '1)
                r32 = rem ? '0 : a32;               // Signed overflow
            else if (uns)
                r32 = rem ? a32 % b32 : a32 / b32;
            else
                r32 = rem ? $signed(a32) % $signed(b32) : $signed(a32) / $signed(b32);
            r = {{32{r32[31]}}, r32};               // W results sign-extend
        end else begin
            if (b == '0)
                r = rem ? a : '1;
            else if (!uns && a == 64'h8000_0000_0000_0000 && b == '1)
                r = rem ? '0 : a;
            else if (uns)
                r = rem ? a % b : a / b;
            else
                r = rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        end
        return r;
    endfunction

    // Waits for a free lane and holds valid for one edge
    task automatic issue(input div_op_e op, input xlen_t a, input xlen_t b);
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_op    = op;
        in_rs1   = a;
        in_rs2   = b;
        in_tag   = next_tag;
        exp_result[next_tag] = expected_result(op, a, b);
        word_op[next_tag]    = op[DIV_OP_WORD_BIT];
        issue_cyc[next_tag]  = cyc;
        sent[next_tag]       = sent[next_tag] + 1;
        issued++;
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic flush_lanes();
        flush = 1'b1;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (sent[t] != got[t] + killed[t]) begin
                killed[t] = killed[t] + 1;
                killed_total++;
            end
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic drain();
        while (issued != received + killed_total) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Result bookkeeping and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES)
            abort_with("Timeout, results stopped arriving");
        if (rstn && out_valid) begin
            got[out_tag] <= got[out_tag] + 1;
            received     <= received + 1;
        end
        if (!in_ready)
            saw_full <= 1'b1;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> out_result == exp_result[out_tag])
        else abort_with($sformatf("ERROR time=%0t out_result_o got %h expected %h", $time,
                                  $sampled(out_result), exp_result[$sampled(out_tag)]));

    // Tag must be in flight so each result shows once and none after a flush
    assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> sent[out_tag] == got[out_tag] + killed[out_tag] + 1)
        else abort_with($sformatf("Tag %0d returned with no operation in flight",
                                  $sampled(out_tag)));

    assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> cyc - issue_cyc[out_tag] >= (word_op[out_tag] ? 10 : 18))
        else abort_with($sformatf("Result for tag %0d came out too early",
                                  $sampled(out_tag)));

    assert property (@(posedge clk) disable iff (!rstn)
        flush |=> in_ready)
        else abort_with("in_ready_o was low on the cycle after a flush");

    initial begin
        div_op_e op;
        xlen_t   a;
        xlen_t   b;
        seed     = 24;
        rstn     = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_DIV;
        in_rs1   = '0;
        in_rs2   = '0;
        in_tag   = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Zero divisor in every operation with junk above the W divisor
        for (int i = 0; i < 8; i++)
            issue(div_op_e'(i[2:0]), rand64(), i[2] ? 64'h5A5A_A5A5_0000_0000 : '0);

        // Signed overflow and sign extension
        issue(OP_DIV, 64'h8000_0000_0000_0000, '1);
        issue(OP_REM, 64'h8000_0000_0000_0000, '1);
        issue(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF);
        issue(OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF);
        issue(OP_DIVUW, 64'h0000_0000_FFFF_FFFE, 64'h1);
        issue(OP_REMUW, 64'hFFFF_FFFF_F000_0003, 64'h7000_0000);
        drain();

        // Both lanes finish on the same edge and lane 1 waits a cycle
        issue(OP_DIV, rand64(), 64'd7);
        repeat (7) @(posedge clk);
        #1;
        issue(OP_DIVW, rand64(), 64'd3);
        drain();

        // Kill two operations mid-flight
        issue(OP_DIVU, rand64(), rand64() >> 20);
        issue(OP_REM, rand64(), rand64() >> 33);
        repeat (5) @(posedge clk);
        #1;
        flush_lanes();
        repeat (30) @(posedge clk);
        #1;

        // Flush lands in the cycle the finished result is shown
        issue(OP_REMW, rand64(), 64'd5);
        repeat (9) @(posedge clk);
        #1;
        flush_lanes();
        repeat (12) @(posedge clk);
        #1;

        for (int n = 0; n < NUM_RAND; n++) begin
            op = div_op_e'(3'($random(seed)));
            a  = rand64();
            b  = rand64() >> ($unsigned($random(seed)) % 64);
            if ($random(seed) & 1)
                b = -b;                         // Negative divisors too
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);                 // Occasional idle cycle
                #1;
            end
            issue(op, a, b);
        end
        drain();
        repeat (20) @(posedge clk);
        #1;

        if (saw_full) begin
            $display("test passed");
            $finish;
        end else begin
            abort_with("in_ready_o never dropped with both lanes busy");
        end
    end

endmodule

/* div_unit.f */
+incdir+hw
hw/div_isa_pkg.sv
hw/div_pipe_pkg.sv
hw/div_lane_if.sv
hw/div_operand_prep.sv
hw/div_radix16_step.sv
hw/div_lane.sv
hw/div_unit.sv
tests/tb_div_unit.sv

/* Makefile */
TOP := tb_div_unit

all: run

build:
	verilator --binary --timing --assert -f div_unit.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall -f div_unit.f --top-module div_unit

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
